/* rtl/core_types_pkg.sv */
// sizes, index types and ALU register-immediate opcodes shared by the back end
// modules pull these in with a wildcard import in the module body
package core_types_pkg;

    // ----------------------------------------------------------
    // sizes
    // ----------------------------------------------------------

    // physical register file
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = 6;

    // reorder buffer
    localparam int ROB_ENTRIES = 64;
    localparam int LOG_ROB_ENTRIES = 6;

    // dispatch queue depth and pointer width
    localparam int DQ_ENTRIES = 8;
    localparam int LOG_DQ_ENTRIES = 3;

    // enqueue, dequeue and pipe width
    localparam int LANES = 4;

    // ----------------------------------------------------------
    // types
    // ----------------------------------------------------------

    typedef logic [LOG_PR_COUNT-1:0] pr_idx_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;

    typedef enum logic [3:0] {
        ADDI  = 4'h0,
        SLTI  = 4'h1,
        SLTIU = 4'h2,
        XORI  = 4'h3,
        ORI   = 4'h4,
        ANDI  = 4'h5,
        SLLI  = 4'h6,
        SRLI  = 4'h7,
        SRAI  = 4'h8,
        LUI   = 4'h9
    } alu_imm_op_t;

endpackage

/* rtl/alu_imm_op_if.sv */
// four-lane bundle of renamed register-immediate ops with per-lane ready
// a lane moves on a clock edge where its valid and ready are both high
interface alu_imm_op_if;

    import core_types_pkg::*;

    // per-lane op fields
    logic [LANES-1:0]       valid;
    alu_imm_op_t [LANES-1:0] op;
    logic [LANES-1:0][31:0] imm;
    pr_idx_t [LANES-1:0]    A_PR;
    logic [LANES-1:0]       A_unneeded;
    pr_idx_t [LANES-1:0]    dest_PR;
    rob_idx_t [LANES-1:0]   ROB_index;

    // per-lane back-pressure
    logic [LANES-1:0]       ready;

    modport producer (
        output valid,
        output op,
        output imm,
        output A_PR,
        output A_unneeded,
        output dest_PR,
        output ROB_index,
        input  ready
    );

    modport consumer (
        input  valid,
        input  op,
        input  imm,
        input  A_PR,
        input  A_unneeded,
        input  dest_PR,
        input  ROB_index,
        output ready
    );

endinterface

/* rtl/alu_imm_dq.sv */
// in-order dispatch queue for ALU register-immediate ops
// takes up to four ops per cycle and offers the four oldest on the dequeue lanes
module alu_imm_dq (
    input  logic CLK,
    input  logic nRST,

    alu_imm_op_if.consumer enq,
    alu_imm_op_if.producer deq
);

    import core_types_pkg::*;

    // ----------------------------------------------------------
    // queue storage and pointers
    // ----------------------------------------------------------

    logic [DQ_ENTRIES-1:0] valid_by_entry;
    alu_imm_op_t           op_by_entry         [DQ_ENTRIES];
    logic [31:0]           imm_by_entry        [DQ_ENTRIES];
    pr_idx_t               A_PR_by_entry       [DQ_ENTRIES];
    logic                  A_unneeded_by_entry [DQ_ENTRIES];
    pr_idx_t               dest_PR_by_entry    [DQ_ENTRIES];
    rob_idx_t              ROB_index_by_entry  [DQ_ENTRIES];

    // one rotating index per lane
    logic [LANES-1:0][LOG_DQ_ENTRIES-1:0] enq_idx;
    logic [LANES-1:0][LOG_DQ_ENTRIES-1:0] deq_idx;

    logic [LANES-1:0] enq_acc;
    logic [LANES-1:0] deq_acc;
    logic [LOG_DQ_ENTRIES-1:0] enq_step;
    logic [LOG_DQ_ENTRIES-1:0] deq_step;

    // pointer advance is one plus the highest accepted lane
    function automatic logic [LOG_DQ_ENTRIES-1:0] advance(input logic [LANES-1:0] acc);
        logic [LOG_DQ_ENTRIES-1:0] step;
        step = '0;
        for (int i = 0; i < LANES; i++) begin
            if (acc[i]) begin
                step = LOG_DQ_ENTRIES'(i + 1);
            end
        end
        return step;
    endfunction

    // ----------------------------------------------------------
    // lane handshakes
    // ----------------------------------------------------------

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            // target entry must be free
            enq.ready[i] = ~valid_by_entry[enq_idx[i]];

            deq.valid[i] = valid_by_entry[deq_idx[i]];
            deq.op[i] = op_by_entry[deq_idx[i]];
            deq.imm[i] = imm_by_entry[deq_idx[i]];
            deq.A_PR[i] = A_PR_by_entry[deq_idx[i]];
            deq.A_unneeded[i] = A_unneeded_by_entry[deq_idx[i]];
            deq.dest_PR[i] = dest_PR_by_entry[deq_idx[i]];
            deq.ROB_index[i] = ROB_index_by_entry[deq_idx[i]];
        end
    end

    assign enq_acc = enq.valid & enq.ready;
    assign deq_acc = deq.valid & deq.ready;
    assign enq_step = advance(enq_acc);
    assign deq_step = advance(deq_acc);

    // ----------------------------------------------------------
    // entry state
    // ----------------------------------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_by_entry <= '0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (enq_acc[i]) begin
                    valid_by_entry[enq_idx[i]] <= 1'b1;
                end
                // free the slot that was read out
                if (deq_acc[i]) begin
                    valid_by_entry[deq_idx[i]] <= 1'b0;
                end
            end
        end
    end

    // payload, written only on accepted lanes
    always_ff @(posedge CLK) begin
        for (int i = 0; i < LANES; i++) begin
            if (enq_acc[i]) begin
                op_by_entry[enq_idx[i]] <= enq.op[i];
                imm_by_entry[enq_idx[i]] <= enq.imm[i];
                A_PR_by_entry[enq_idx[i]] <= enq.A_PR[i];
                A_unneeded_by_entry[enq_idx[i]] <= enq.A_unneeded[i];
                dest_PR_by_entry[enq_idx[i]] <= enq.dest_PR[i];
                ROB_index_by_entry[enq_idx[i]] <= enq.ROB_index[i];
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < LANES; i++) begin
                enq_idx[i] <= LOG_DQ_ENTRIES'(i);
                deq_idx[i] <= LOG_DQ_ENTRIES'(i);
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                enq_idx[i] <= enq_idx[i] + enq_step;
                deq_idx[i] <= deq_idx[i] + deq_step;
            end
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // valid lanes fill from lane 0 upward with no gaps
    a_enq_prefix: assert property (@(posedge CLK) disable iff (!nRST)
        ((enq.valid + 4'd1) & enq.valid) == '0);

    // an accepted lane never steps the pointer past an occupied entry
    for (genvar i = 1; i < LANES; i++) begin : g_enq_chk
        a_enq_free: assert property (@(posedge CLK) disable iff (!nRST)
            enq_acc[i] |-> &enq.ready[i-1:0]);
    end

endmodule

/* rtl/alu_imm_pipe.sv */
// one lane of the register-immediate execute path
// operand read from the register file, then execute, writeback and completion
module alu_imm_pipe #(
    parameter int LANE = 0
) (
    input  logic CLK,
    input  logic nRST,

    alu_imm_op_if.consumer deq,

    input  logic wb_stall,

    // register file read port
    output core_types_pkg::pr_idx_t rd_addr,
    input  logic [31:0]             rd_data,

    // register file write port
    output logic                    wr_en,
    output core_types_pkg::pr_idx_t wr_addr,
    output logic [31:0]             wr_data,

    // completion towards the ROB
    output logic                     complete_valid,
    output core_types_pkg::rob_idx_t complete_ROB_index,
    output core_types_pkg::pr_idx_t  complete_dest_PR,
    output logic [31:0]              complete_result
);

    import core_types_pkg::*;

    logic deq_fire;

    // stage one, operand read
    logic        s1_valid;
    alu_imm_op_t s1_op;
    logic [31:0] s1_imm;
    pr_idx_t     s1_A_PR;
    logic        s1_A_unneeded;
    pr_idx_t     s1_dest_PR;
    rob_idx_t    s1_ROB_index;

    // stage two, execute
    logic        ex_valid;
    alu_imm_op_t ex_op;
    logic [31:0] ex_imm;
    logic [31:0] ex_a;
    pr_idx_t     ex_dest_PR;
    rob_idx_t    ex_ROB_index;

    logic [4:0]  shamt;
    logic [31:0] result;

    // whole pipe holds under stall, so no new op may enter
    assign deq.ready[LANE] = !wb_stall;
    assign deq_fire = deq.valid[LANE] & deq.ready[LANE];

    assign rd_addr = s1_A_PR;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            s1_valid <= 1'b0;
            ex_valid <= 1'b0;
            complete_valid <= 1'b0;
        end else if (!wb_stall) begin
            s1_valid <= deq_fire;
            ex_valid <= s1_valid;
            complete_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (deq_fire) begin
            s1_op <= deq.op[LANE];
            s1_imm <= deq.imm[LANE];
            s1_A_PR <= deq.A_PR[LANE];
            s1_A_unneeded <= deq.A_unneeded[LANE];
            s1_dest_PR <= deq.dest_PR[LANE];
            s1_ROB_index <= deq.ROB_index[LANE];
        end
        if (!wb_stall && s1_valid) begin
            ex_op <= s1_op;
            ex_imm <= s1_imm;
            // no source register means A reads as zero
            ex_a <= s1_A_unneeded ? '0 : rd_data;
            ex_dest_PR <= s1_dest_PR;
            ex_ROB_index <= s1_ROB_index;
        end
        if (!wb_stall && ex_valid) begin
            complete_ROB_index <= ex_ROB_index;
            complete_dest_PR <= ex_dest_PR;
            complete_result <= result;
        end
    end

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------

    assign shamt = ex_imm[4:0];

    always_comb begin
        case (ex_op)
            ADDI:    result = ex_a + ex_imm;
            SLTI:    result = {31'b0, $signed(ex_a) < $signed(ex_imm)};
            SLTIU:   result = {31'b0, ex_a < ex_imm};
            XORI:    result = ex_a ^ ex_imm;
            ORI:     result = ex_a | ex_imm;
            ANDI:    result = ex_a & ex_imm;
            SLLI:    result = ex_a << shamt;
            SRLI:    result = ex_a >> shamt;
            SRAI:    result = $signed(ex_a) >>> shamt;
            LUI:     result = ex_imm << 12;
            default: result = '0;
        endcase
    end

    // write lands on the same edge the completion registers load
    assign wr_en = ex_valid & !wb_stall;
    assign wr_addr = ex_dest_PR;
    assign wr_data = result;

    a_cmpl_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown(complete_valid));

endmodule

/* rtl/phys_reg_file.sv */
// physical register file, four combinational read ports and five write ports
// ports 0 to 3 belong to the ALU pipes, port 4 carries writeback from other units
module phys_reg_file (
    input  logic CLK,
    input  logic nRST,

    input  core_types_pkg::pr_idx_t [core_types_pkg::LANES-1:0] rd_addr,
    output logic [core_types_pkg::LANES-1:0][31:0]              rd_data,

    input  logic [core_types_pkg::LANES:0]                      wr_en,
    input  core_types_pkg::pr_idx_t [core_types_pkg::LANES:0]   wr_addr,
    input  logic [core_types_pkg::LANES:0][31:0]                wr_data
);

    import core_types_pkg::*;

    logic [31:0] regs [PR_COUNT];
    logic        wr_clash;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            rd_data[i] = regs[rd_addr[i]];
        end
    end

    // higher port wins if two ever collide
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < PR_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i <= LANES; i++) begin
                if (wr_en[i]) begin
                    regs[wr_addr[i]] <= wr_data[i];
                end
            end
        end
    end

    // renaming gives every writer its own register
    always_comb begin
        wr_clash = 1'b0;
        for (int i = 0; i <= LANES; i++) begin
            for (int j = i + 1; j <= LANES; j++) begin
                if (wr_en[i] && wr_en[j] && wr_addr[i] == wr_addr[j]) begin
                    wr_clash = 1'b1;
                end
            end
        end
    end

    a_no_wr_clash: assert property (@(posedge CLK) disable iff (!nRST) !wr_clash);

endmodule

/* rtl/alu_imm_top.sv */
// register-immediate back end: dispatch queue, four ALU pipes and register file
// plain lane-array ports towards rename, the ROB and the other writeback units
module alu_imm_top (
    input  logic CLK,
    input  logic nRST,

    // four-lane enqueue from rename
    input  logic [core_types_pkg::LANES-1:0]                        enq_valid,
    input  core_types_pkg::alu_imm_op_t [core_types_pkg::LANES-1:0] enq_op,
    input  logic [core_types_pkg::LANES-1:0][31:0]                  enq_imm,
    input  core_types_pkg::pr_idx_t [core_types_pkg::LANES-1:0]     enq_A_PR,
    input  logic [core_types_pkg::LANES-1:0]                        enq_A_unneeded,
    input  core_types_pkg::pr_idx_t [core_types_pkg::LANES-1:0]     enq_dest_PR,
    input  core_types_pkg::rob_idx_t [core_types_pkg::LANES-1:0]    enq_ROB_index,
    output logic [core_types_pkg::LANES-1:0]                        enq_ready,

    input  logic wb_stall,

    // writeback from other functional units
    input  logic                    ext_wr_en,
    input  core_types_pkg::pr_idx_t ext_wr_addr,
    input  logic [31:0]             ext_wr_data,

    // completion towards the ROB
    output logic [core_types_pkg::LANES-1:0]                     complete_valid,
    output core_types_pkg::rob_idx_t [core_types_pkg::LANES-1:0] complete_ROB_index,
    output core_types_pkg::pr_idx_t [core_types_pkg::LANES-1:0]  complete_dest_PR,
    output logic [core_types_pkg::LANES-1:0][31:0]               complete_result
);

    import core_types_pkg::*;

    alu_imm_op_if enq_if ();
    alu_imm_op_if deq_if ();

    pr_idx_t [LANES-1:0]    rd_addr;
    logic [LANES-1:0][31:0] rd_data;
    logic [LANES:0]         wr_en;
    pr_idx_t [LANES:0]      wr_addr;
    logic [LANES:0][31:0]   wr_data;

    // ----------------------------------------------------------
    // enqueue bundle
    // ----------------------------------------------------------

    assign enq_if.valid = enq_valid;
    assign enq_if.op = enq_op;
    assign enq_if.imm = enq_imm;
    assign enq_if.A_PR = enq_A_PR;
    assign enq_if.A_unneeded = enq_A_unneeded;
    assign enq_if.dest_PR = enq_dest_PR;
    assign enq_if.ROB_index = enq_ROB_index;
    assign enq_ready = enq_if.ready;

    alu_imm_dq i_dq (
        .CLK  (CLK),
        .nRST (nRST),
        .enq  (enq_if.consumer),
        .deq  (deq_if.producer)
    );

    // ----------------------------------------------------------
    // pipes and register file
    // ----------------------------------------------------------

    for (genvar i = 0; i < LANES; i++) begin : g_pipe
        alu_imm_pipe #(
            .LANE (i)
        ) i_pipe (
            .CLK                (CLK),
            .nRST               (nRST),
            .deq                (deq_if.consumer),
            .wb_stall           (wb_stall),
            .rd_addr            (rd_addr[i]),
            .rd_data            (rd_data[i]),
            .wr_en              (wr_en[i]),
            .wr_addr            (wr_addr[i]),
            .wr_data            (wr_data[i]),
            .complete_valid     (complete_valid[i]),
            .complete_ROB_index (complete_ROB_index[i]),
            .complete_dest_PR   (complete_dest_PR[i]),
            .complete_result    (complete_result[i])
        );
    end

    // last write port is the external one
    assign wr_en[LANES] = ext_wr_en;
    assign wr_addr[LANES] = ext_wr_addr;
    assign wr_data[LANES] = ext_wr_data;

    phys_reg_file i_prf (
        .CLK     (CLK),
        .nRST    (nRST),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule

/* verif/alu_imm_tb.sv */
// testbench for the register-immediate back end, random ops checked against a reference model
// built and run by the Verilator script in the project root
module alu_imm_tb;

    import core_types_pkg::*;

    localparam int NUM_OPS = 200;
    localparam int PRELOAD_REGS = 32;
    localparam int LONG_STALL_CYCLES = 16;
    // 10 reset + 32 preload + 200 ops at up to a few cycles each, stalls and drains
    localparam int CYCLE_LIMIT = 4000;

    typedef struct packed {
        alu_imm_op_t op;
        logic [31:0] imm;
        pr_idx_t     a;
        logic        a_un;
        pr_idx_t     dest;
        rob_idx_t    rob;
    } op_t;

    typedef struct packed {
        alu_imm_op_t op;
        rob_idx_t    rob;
        pr_idx_t     dest;
        logic [31:0] res;
    } cmpl_t;

    logic CLK;
    logic nRST;
    logic [LANES-1:0]           enq_valid;
    alu_imm_op_t [LANES-1:0]    enq_op;
    logic [LANES-1:0][31:0]     enq_imm;
    pr_idx_t [LANES-1:0]        enq_A_PR;
    logic [LANES-1:0]           enq_A_unneeded;
    pr_idx_t [LANES-1:0]        enq_dest_PR;
    rob_idx_t [LANES-1:0]       enq_ROB_index;
    logic [LANES-1:0]           enq_ready;
    logic                       wb_stall;
    logic                       ext_wr_en;
    pr_idx_t                    ext_wr_addr;
    logic [31:0]                ext_wr_data;
    logic [LANES-1:0]           complete_valid;
    rob_idx_t [LANES-1:0]       complete_ROB_index;
    pr_idx_t [LANES-1:0]        complete_dest_PR;
    logic [LANES-1:0][31:0]     complete_result;

    int errors = 0;
    int completed = 0;
    int cycle_count = 0;
    int burst_left = 0;
    int held_accepts = 0;
    logic [31:0] lfsr = 32'hbed;
    logic [31:0] src_regs [PRELOAD_REGS];
    op_t pending[$];
    cmpl_t expected[$];
    logic sending = 1'b0;
    logic random_stalls = 1'b0;
    logic long_stall = 1'b0;
    logic last_stall = 1'b0;
    logic seen_cmpl = 1'b0;
    rob_idx_t next_rob = '0;

    alu_imm_top i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        wait (cycle_count == CYCLE_LIMIT);
        $display("timeout after %0d cycles, %0d ops still outstanding", CYCLE_LIMIT,
            expected.size() + pending.size());
        $display("errors: %0d, completions: %0d of %0d", errors, completed, NUM_OPS);
        $display("Test FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // random source and reference model
    // ----------------------------------------------------------

    // galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] model_alu(input alu_imm_op_t op, input logic [31:0] a,
                                              input logic [31:0] imm);
        logic [63:0] ext;
        logic [31:0] r;
        ext = {{32{a[31]}}, a} >> imm[4:0];
        case (op)
            ADDI:    r = a + imm;
            // differing signs decide a signed compare on their own
            SLTI:    r = (a[31] != imm[31]) ? {31'h0, a[31]} : {31'h0, a < imm};
            SLTIU:   r = {31'h0, a < imm};
            XORI:    r = a ^ imm;
            ORI:     r = a | imm;
            ANDI:    r = a & imm;
            SLLI:    r = a << imm[4:0];
            SRLI:    r = a >> imm[4:0];
            SRAI:    r = ext[31:0];
            LUI:     r = {imm[19:0], 12'h0};
            default: r = 32'h0;
        endcase
        return r;
    endfunction

    task automatic make_ops();
        op_t o;
        for (int k = 0; k < NUM_OPS; k++) begin
            o.op = alu_imm_op_t'(4'(rand_bits(4) % 10));
            o.imm = rand_bits(32);
            o.a = pr_idx_t'(rand_bits(5));
            o.a_un = (rand_bits(3) == 0);
            o.rob = next_rob;
            // dest tied to the ROB index keeps writers in one cycle apart
            o.dest = {1'b1, next_rob[4:0]};
            next_rob++;
            pending.push_back(o);
        end
    endtask

    // ----------------------------------------------------------
    // per-cycle drive and checks
    // ----------------------------------------------------------

    task automatic check_completions();
        cmpl_t e;
        for (int i = 0; i < LANES; i++) begin
            if (complete_valid[i]) begin
                seen_cmpl = 1'b1;
                if (expected.size() == 0) begin
                    errors++;
                    $display("lane %0d completed ROB index %0d with no op outstanding", i,
                        complete_ROB_index[i]);
                end else begin
                    e = expected.pop_front();
                    completed++;
                    assert (complete_ROB_index[i] == e.rob) else begin
                        errors++;
                        $display("FAIL order lane %0d: expected ROB %0d, actual %0d", i,
                            e.rob, complete_ROB_index[i]);
                    end
                    assert (complete_dest_PR[i] == e.dest) else begin
                        errors++;
                        $display("FAIL writeback ROB %0d: expected dest %0d, actual %0d",
                            e.rob, e.dest, complete_dest_PR[i]);
                    end
                    assert (complete_result[i] == e.res) else begin
                        errors++;
                        $display("FAIL arithmetic %s ROB %0d: expected %h, actual %h",
                            e.op.name(), e.rob, e.res, complete_result[i]);
                    end
                end
            end
        end
    endtask

    task automatic step_cycle();
        int w;
        int n;
        op_t o;
        cmpl_t e;
        logic [31:0] a;
        @(posedge CLK);
        #10;
        if (long_stall) begin
            wb_stall = 1'b1;
        end else if (burst_left > 0) begin
            wb_stall = 1'b1;
            burst_left--;
        end else if (random_stalls && rand_bits(3) == 0) begin
            wb_stall = 1'b1;
            burst_left = int'(rand_bits(2));
        end else begin
            wb_stall = 1'b0;
        end
        w = 0;
        if (sending) begin
            w = int'(rand_bits(2)) + 1;
            if (w > pending.size()) begin
                w = pending.size();
            end
        end
        for (int i = 0; i < LANES; i++) begin
            if (i < w) begin
                o = pending[i];
            end else begin
                o = '0;
            end
            enq_valid[i] = (i < w);
            enq_op[i] = o.op;
            enq_imm[i] = o.imm;
            enq_A_PR[i] = o.a;
            enq_A_unneeded[i] = o.a_un;
            enq_dest_PR[i] = o.dest;
            enq_ROB_index[i] = o.rob;
        end

        @(negedge CLK);
        // outputs only reload on an edge where the pipes moved
        if (!last_stall) begin
            check_completions();
        end
        last_stall = wb_stall;
        n = 0;
        while (n < w && enq_ready[n]) begin
            n++;
        end
        assert ((enq_valid & enq_ready) == LANES'((1 << n) - 1)) else begin
            errors++;
            $display("accepted enqueue lanes %b are not a prefix", enq_valid & enq_ready);
        end
        if (long_stall) begin
            if (held_accepts >= DQ_ENTRIES) begin
                assert (enq_ready == '0) else begin
                    errors++;
                    $display("FAIL back-pressure: expected enq_ready %b, actual %b",
                        4'b0000, enq_ready);
                end
            end else begin
                assert (enq_ready[0]) else begin
                    errors++;
                    $display("queue refused lane 0 with only %0d ops held", held_accepts);
                end
            end
            held_accepts += n;
        end
        for (int i = 0; i < n; i++) begin
            o = pending.pop_front();
            a = o.a_un ? 32'h0 : src_regs[o.a[4:0]];
            e.op = o.op;
            e.rob = o.rob;
            e.dest = o.dest;
            e.res = model_alu(o.op, a, o.imm);
            expected.push_back(e);
        end
    endtask

    // held pipes keep every completion output
    a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
        wb_stall && seen_cmpl |=> $stable(complete_valid) && $stable(complete_ROB_index)
            && $stable(complete_dest_PR) && $stable(complete_result))
    else begin
        errors++;
        $display("completion outputs changed while wb_stall was high");
    end

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------

    initial begin
        nRST = 1'b0;
        enq_valid = '0;
        enq_op = '{default: ADDI};
        enq_imm = '0;
        enq_A_PR = '0;
        enq_A_unneeded = '0;
        enq_dest_PR = '0;
        enq_ROB_index = '0;
        wb_stall = 1'b0;
        ext_wr_en = 1'b0;
        ext_wr_addr = '0;
        ext_wr_data = '0;
        repeat (10) @(posedge CLK);
        #10;
        nRST = 1'b1;
        @(negedge CLK);
        assert (enq_ready == '1 && complete_valid == '0) else begin
            errors++;
            $display("FAIL reset: expected ready 1111 valid 0000, actual ready %b valid %b",
                enq_ready, complete_valid);
        end

        // source registers through the external write port
        for (int r = 0; r < PRELOAD_REGS; r++) begin
            @(posedge CLK);
            #10;
            src_regs[r] = rand_bits(32);
            ext_wr_en = 1'b1;
            ext_wr_addr = pr_idx_t'(r);
            ext_wr_data = src_regs[r];
        end
        @(posedge CLK);
        #10;
        ext_wr_en = 1'b0;

        make_ops();
        sending = 1'b1;
        random_stalls = 1'b1;
        while (pending.size() > NUM_OPS / 2) begin
            step_cycle();
        end

        // drain before the long stall so the queue starts empty
        sending = 1'b0;
        random_stalls = 1'b0;
        while (expected.size() != 0 || burst_left != 0) begin
            step_cycle();
        end
        long_stall = 1'b1;
        sending = 1'b1;
        repeat (LONG_STALL_CYCLES) step_cycle();
        long_stall = 1'b0;
        assert (held_accepts == DQ_ENTRIES) else begin
            errors++;
            $display("long stall held %0d ops instead of a full queue", held_accepts);
        end

        random_stalls = 1'b1;
        while (pending.size() != 0) begin
            step_cycle();
        end
        sending = 1'b0;
        random_stalls = 1'b0;
        while (expected.size() != 0 || burst_left != 0) begin
            step_cycle();
        end
        // a few idle cycles to catch stray completions
        repeat (4) step_cycle();
        assert (completed == NUM_OPS) else begin
            errors++;
            $display("FAIL completions: expected %0d, actual %0d", NUM_OPS, completed);
        end

        $display("errors: %0d, completions: %0d of %0d", errors, completed, NUM_OPS);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* alu_imm_dispatch.f */
rtl/core_types_pkg.sv
rtl/alu_imm_op_if.sv
rtl/alu_imm_dq.sv
rtl/alu_imm_pipe.sv
rtl/phys_reg_file.sv
rtl/alu_imm_top.sv
verif/alu_imm_tb.sv

/* run_sim.sh */
#!/bin/sh
# compiles the register-immediate back end and its testbench with Verilator, runs it,
# then decides pass or fail from the simulation log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 --top-module alu_imm_tb \
    -f alu_imm_dispatch.f -o alu_imm_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/alu_imm_sim > sim.log 2>&1 || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
